/* Bender.yml */
package:
  name: pool_engine

sources:
  - source/pool_pkg.sv
  - source/pool_regs.sv
  - source/line_buffer.sv
  - source/window_pool.sv
  - source/pool_top.sv
  - target: simulation
    files:
      - testbench/pool_checker.sv
      - testbench/tb_pool_top.sv

/* source/line_buffer.sv */
/* Two-row line buffer for a 3x3 window, rows up to MAX_WIDTH pixels
   img_width and img_height must stay fixed while a frame streams */

`timescale 1ns/10ps
`default_nettype none

module line_buffer (
    input  wire                   axi_clk,
    input  wire                   axi_reset_n,
    input  wire pool_pkg::pixel_t s_axis_data,
    input  wire                   pixel_take,
    input  wire pool_pkg::coord_t img_width,
    input  wire pool_pkg::coord_t img_height,
    output pool_pkg::pixel_t      col_top,
    output pool_pkg::pixel_t      col_mid,
    output pool_pkg::pixel_t      col_bot,
    output logic                  window_ok,
    output logic                  frame_end
);
    import pool_pkg::*;

    pixel_t row1_mem [MAX_WIDTH]; // One row back
    pixel_t row2_mem [MAX_WIDTH]; // Two rows back
    coord_t col_q;
    coord_t row_q;
    logic   last_col;
    logic   last_row;

    // ------------------------------------------------------------------
    // Column presented alongside the incoming pixel
    // ------------------------------------------------------------------
    assign col_top = row2_mem[col_q];
    assign col_mid = row1_mem[col_q];
    assign col_bot = s_axis_data;      // Current row comes straight from the stream

    assign last_col  = (col_q == img_width - coord_t'(1));
    assign last_row  = (row_q == img_height - coord_t'(1));
    assign window_ok = (col_q >= coord_t'(KERNEL_SIZE - 1)) &&
                       (row_q >= coord_t'(KERNEL_SIZE - 1));
    assign frame_end = last_col && last_row;

    // Rows move down by one at the current column
    always_ff @(posedge axi_clk) begin
        if (pixel_take) begin
            row2_mem[col_q] <= row1_mem[col_q];
            row1_mem[col_q] <= s_axis_data;
        end
    end

    // Position counters, wrap at row end and frame end
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_take) begin
            if (last_col) begin
                col_q <= '0;
                row_q <= last_row ? coord_t'(0) : row_q + coord_t'(1);
            end else begin
                col_q <= col_q + coord_t'(1);
            end
        end
    end

    // Width change mid-frame would leave the counter past the row end
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        pixel_take |-> (col_q < img_width));

endmodule

`default_nettype wire

/* source/pool_pkg.sv */
/* Widths, register map and kernel constants shared by the pooling engine
   Register addresses are byte addresses on a 10-bit AXI4-Lite port */

`default_nettype none

package pool_pkg;

    // ------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------
    typedef logic [31:0] pixel_t;     // One stream pixel or register word
    typedef logic [9:0]  axil_addr_t; // Control port byte address
    typedef logic [10:0] coord_t;     // Column or row position, covers MAX_WIDTH
    typedef logic [35:0] sum_t;       // Nine 32-bit pixels added without overflow

    // ------------------------------------------------------------------
    // Kernel geometry
    // ------------------------------------------------------------------
    localparam int KERNEL_SIZE = 3;                         // Window side
    localparam int K_SQUARED   = KERNEL_SIZE * KERNEL_SIZE; // Pixels per window
    localparam int MAX_WIDTH   = 1800;                      // Deepest row held

    // Register map
    localparam axil_addr_t REG_CTRL   = 10'd0;  // Bit 0 is start
    localparam axil_addr_t REG_CLEAR  = 10'd4;  // Bit 0 zeroes all registers
    localparam axil_addr_t REG_WIDTH  = 10'd16; // Image width in pixels
    localparam axil_addr_t REG_HEIGHT = 10'd20; // Image height in rows

    // Control port transaction states
    typedef enum logic [1:0] {
        AXIL_IDLE,  // Both address channels open
        AXIL_WDATA, // Waiting for write data
        AXIL_WRESP, // Write response pending
        AXIL_RDATA  // Read data pending
    } axil_state_t;

endpackage

`default_nettype wire

/* source/pool_regs.sv */
/* AXI4-Lite register file, one transaction at a time, write wins a tie
   Unmapped addresses read 0 and drop writes; a clear takes one extra cycle */

`timescale 1ns/10ps
`default_nettype none

module pool_regs (
    input  wire                    axi_clk,
    input  wire                    axi_reset_n,
    input  wire pool_pkg::axil_addr_t s_axi_awaddr,
    input  wire                    s_axi_awvalid,
    output logic                   s_axi_awready,
    input  wire pool_pkg::pixel_t  s_axi_wdata,
    input  wire                    s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic                   s_axi_bvalid,
    input  wire                    s_axi_bready,
    input  wire pool_pkg::axil_addr_t s_axi_araddr,
    input  wire                    s_axi_arvalid,
    output logic                   s_axi_arready,
    output pool_pkg::pixel_t       s_axi_rdata,
    output logic                   s_axi_rvalid,
    input  wire                    s_axi_rready,
    output logic                   start,
    output pool_pkg::coord_t       img_width,
    output pool_pkg::coord_t       img_height
);
    import pool_pkg::*;

    axil_state_t state;
    axil_addr_t  addr_q;      // Address of the transaction in progress
    logic        start_q;
    logic        clear_q;     // Set by software, zeroes everything next cycle
    coord_t      width_q;
    coord_t      height_q;
    logic        write_fire;

    assign write_fire = (state == AXIL_WDATA) && s_axi_wvalid && s_axi_wready;

    // ------------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            state         <= AXIL_IDLE;
            s_axi_awready <= 1'b1;
            s_axi_arready <= 1'b1;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            case (state)
                AXIL_IDLE: begin
                    if (s_axi_awvalid && s_axi_awready) begin // Write has priority
                        state         <= AXIL_WDATA;
                        s_axi_awready <= 1'b0;
                        s_axi_arready <= 1'b0;
                        s_axi_wready  <= 1'b1;
                    end else if (s_axi_arvalid && s_axi_arready) begin
                        state         <= AXIL_RDATA;
                        s_axi_awready <= 1'b0;
                        s_axi_arready <= 1'b0;
                        s_axi_rvalid  <= 1'b1; // Data follows from addr_q
                    end
                end
                AXIL_WDATA: begin
                    if (write_fire) begin
                        state        <= AXIL_WRESP;
                        s_axi_wready <= 1'b0;
                        s_axi_bvalid <= 1'b1;
                    end
                end
                AXIL_WRESP: begin
                    if (s_axi_bready) begin
                        state         <= AXIL_IDLE;
                        s_axi_bvalid  <= 1'b0;
                        s_axi_awready <= 1'b1;
                        s_axi_arready <= 1'b1;
                    end
                end
                default: begin // AXIL_RDATA
                    if (s_axi_rready) begin
                        state         <= AXIL_IDLE;
                        s_axi_rvalid  <= 1'b0;
                        s_axi_awready <= 1'b1;
                        s_axi_arready <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Address latch, same decision order as the FSM
    always_ff @(posedge axi_clk) begin
        if (state == AXIL_IDLE) begin
            if (s_axi_awvalid) begin
                addr_q <= s_axi_awaddr;
            end else if (s_axi_arvalid) begin
                addr_q <= s_axi_araddr;
            end
        end
    end

    // ------------------------------------------------------------------
    // Register storage
    // ------------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n || clear_q) begin
            start_q  <= 1'b0;
            clear_q  <= 1'b0;
            width_q  <= '0;
            height_q <= '0;
        end else if (write_fire) begin
            case (addr_q)
                REG_CTRL:   start_q  <= s_axi_wdata[0];
                REG_CLEAR:  clear_q  <= s_axi_wdata[0];
                REG_WIDTH:  width_q  <= s_axi_wdata[$bits(coord_t)-1:0];
                REG_HEIGHT: height_q <= s_axi_wdata[$bits(coord_t)-1:0];
                default: ; // Unmapped, write dropped
            endcase
        end
    end

    always_comb begin
        case (addr_q)
            REG_CTRL:   s_axi_rdata = pixel_t'(start_q);
            REG_CLEAR:  s_axi_rdata = pixel_t'(clear_q);
            REG_WIDTH:  s_axi_rdata = pixel_t'(width_q);
            REG_HEIGHT: s_axi_rdata = pixel_t'(height_q);
            default:    s_axi_rdata = '0;
        endcase
    end

    assign start      = start_q;
    assign img_width  = width_q;
    assign img_height = height_q;

    // Responses of the two paths never overlap
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        !(s_axi_bvalid && s_axi_rvalid));
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        s_axi_wready |-> (state == AXIL_WDATA));

endmodule

`default_nettype wire

/* source/pool_top.sv */
/* 3x3 average pooling engine, stride 1, one 32-bit channel
   Program width and height before setting start; frames then run back to back */

`timescale 1ns/10ps
`default_nettype none

module pool_top (
    input  wire                       axi_clk,
    input  wire                       axi_reset_n,
    // AXI4-Lite control port
    input  wire pool_pkg::axil_addr_t s_axi_awaddr,
    input  wire                       s_axi_awvalid,
    output wire                       s_axi_awready,
    input  wire pool_pkg::pixel_t     s_axi_wdata,
    input  wire                       s_axi_wvalid,
    output wire                       s_axi_wready,
    output wire                       s_axi_bvalid,
    input  wire                       s_axi_bready,
    input  wire pool_pkg::axil_addr_t s_axi_araddr,
    input  wire                       s_axi_arvalid,
    output wire                       s_axi_arready,
    output wire pool_pkg::pixel_t     s_axi_rdata,
    output wire                       s_axi_rvalid,
    input  wire                       s_axi_rready,
    // AXI4-Stream pixel input
    input  wire                       s_axis_valid,
    input  wire pool_pkg::pixel_t     s_axis_data,
    output wire                       s_axis_ready,
    // AXI4-Stream average output
    output wire                       m_axis_valid,
    output wire pool_pkg::pixel_t     m_axis_data,
    output wire                       m_axis_last,
    input  wire                       m_axis_ready
);
    import pool_pkg::*;

    logic   start;
    coord_t img_width;
    coord_t img_height;
    logic   pixel_take;
    pixel_t col_top;
    pixel_t col_mid;
    pixel_t col_bot;
    logic   window_ok;
    logic   frame_end;

    pool_regs u_regs (
        .axi_clk, .axi_reset_n,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rvalid, .s_axi_rready,
        .start, .img_width, .img_height
    );

    line_buffer u_line_buffer (
        .axi_clk, .axi_reset_n,
        .s_axis_data, .pixel_take, .img_width, .img_height,
        .col_top, .col_mid, .col_bot, .window_ok, .frame_end
    );

    window_pool u_window_pool (
        .axi_clk, .axi_reset_n, .start,
        .s_axis_valid, .s_axis_ready, .pixel_take,
        .col_top, .col_mid, .col_bot, .window_ok, .frame_end,
        .m_axis_valid, .m_axis_data, .m_axis_last, .m_axis_ready
    );

endmodule

`default_nettype wire

/* source/window_pool.sv */
/* Window registers, nine-pixel average and one-deep output stage
   Pixels are taken only while start is set and the output slot can move */

`timescale 1ns/10ps
`default_nettype none

module window_pool (
    input  wire                   axi_clk,
    input  wire                   axi_reset_n,
    input  wire                   start,
    input  wire                   s_axis_valid,
    output logic                  s_axis_ready,
    output logic                  pixel_take,
    input  wire pool_pkg::pixel_t col_top,
    input  wire pool_pkg::pixel_t col_mid,
    input  wire pool_pkg::pixel_t col_bot,
    input  wire                   window_ok,
    input  wire                   frame_end,
    output logic                  m_axis_valid,
    output pool_pkg::pixel_t      m_axis_data,
    output logic                  m_axis_last,
    input  wire                   m_axis_ready
);
    import pool_pkg::*;

    // Index 0 is the oldest column, the last index the newest
    pixel_t top_q [KERNEL_SIZE-1];
    pixel_t mid_q [KERNEL_SIZE-1];
    pixel_t bot_q [KERNEL_SIZE-1];
    sum_t   win_sum;
    sum_t   win_avg;
    logic   beat_load;

    // ------------------------------------------------------------------
    // Stream flow control
    // ------------------------------------------------------------------
    assign s_axis_ready = start && (!m_axis_valid || m_axis_ready); // Slot free or draining
    assign pixel_take   = s_axis_valid && s_axis_ready;
    assign beat_load    = pixel_take && window_ok;

    // Column history shift
    always_ff @(posedge axi_clk) begin
        if (pixel_take) begin
            for (int i = 0; i < KERNEL_SIZE - 2; i++) begin
                top_q[i] <= top_q[i+1];
                mid_q[i] <= mid_q[i+1];
                bot_q[i] <= bot_q[i+1];
            end
            top_q[KERNEL_SIZE-2] <= col_top;
            mid_q[KERNEL_SIZE-2] <= col_mid;
            bot_q[KERNEL_SIZE-2] <= col_bot;
        end
    end

    // ------------------------------------------------------------------
    // Nine-term sum and floor divide
    // ------------------------------------------------------------------
    always_comb begin
        win_sum = sum_t'(col_top) + sum_t'(col_mid) + sum_t'(col_bot); // Incoming column
        for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
            win_sum = win_sum + sum_t'(top_q[i]) + sum_t'(mid_q[i]) + sum_t'(bot_q[i]);
        end
        win_avg = win_sum / sum_t'(K_SQUARED); // Quotient always fits 32 bits
    end

    // Output beat valid flag
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            m_axis_valid <= 1'b0;
        end else if (beat_load) begin
            m_axis_valid <= 1'b1;
        end else if (m_axis_ready) begin
            m_axis_valid <= 1'b0; // Beat consumed, nothing new
        end
    end

    // Output payload, only loaded when the slot is free or draining
    always_ff @(posedge axi_clk) begin
        if (beat_load) begin
            m_axis_data <= win_avg[$bits(pixel_t)-1:0];
            m_axis_last <= frame_end;
        end
    end

    // Held beat must not change under back-pressure
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        (m_axis_valid && !m_axis_ready) |=>
            (m_axis_valid && $stable(m_axis_data) && $stable(m_axis_last)));

endmodule

`default_nettype wire

/* sources.f */
source/pool_pkg.sv
source/pool_regs.sv
source/line_buffer.sv
source/window_pool.sv
source/pool_top.sv
testbench/pool_checker.sv
testbench/tb_pool_top.sv

/* testbench/pool_checker.sv */
/* Scoreboard for the pooling engine, models registers and pixels seen at the ports
   Frames up to 64 x 16 pixels; beats are compared in raster window order */

`timescale 1ns/10ps
`default_nettype none

module pool_checker (
    input  wire                       axi_clk,
    input  wire                       axi_reset_n,
    input  wire [95:0]                test_name,    // Current test, as a string
    input  wire pool_pkg::axil_addr_t s_axi_awaddr,
    input  wire                       s_axi_awvalid,
    input  wire                       s_axi_awready,
    input  wire pool_pkg::pixel_t     s_axi_wdata,
    input  wire                       s_axi_wvalid,
    input  wire                       s_axi_wready,
    input  wire                       s_axi_bvalid,
    input  wire                       s_axi_bready,
    input  wire pool_pkg::axil_addr_t s_axi_araddr,
    input  wire                       s_axi_arvalid,
    input  wire                       s_axi_arready,
    input  wire pool_pkg::pixel_t     s_axi_rdata,
    input  wire                       s_axi_rvalid,
    input  wire                       s_axi_rready,
    input  wire                       s_axis_valid,
    input  wire pool_pkg::pixel_t     s_axis_data,
    input  wire                       s_axis_ready,
    input  wire                       m_axis_valid,
    input  wire pool_pkg::pixel_t     m_axis_data,
    input  wire                       m_axis_last,
    input  wire                       m_axis_ready,
    output int                        errors
);
    import pool_pkg::*;

    pixel_t     img [16][64];  // Mirror of the frame, indexed row then column
    pixel_t     exp_q [$];     // Expected averages, oldest first
    logic       last_q [$];    // Expected last flags
    logic       start_m;       // Register model
    logic       clear_pend;    // Clear lands one cycle after its write
    coord_t     width_m;
    coord_t     height_m;
    axil_addr_t waddr_m;
    axil_addr_t raddr_m;
    logic       bvalid_m;      // Write response owed
    logic       rvalid_m;      // Read data owed
    int         col;
    int         row;
    int         beats;         // Beats seen in the current frame
    logic       beat_due;      // Window completed at the previous edge
    logic       held;          // Beat stalled at the previous edge
    pixel_t     held_data;
    logic       held_last;

    initial errors = 0;

    function automatic pixel_t reg_model(input axil_addr_t addr);
        case (addr)
            REG_CTRL:   reg_model = pixel_t'(start_m);
            REG_WIDTH:  reg_model = pixel_t'(width_m);
            REG_HEIGHT: reg_model = pixel_t'(height_m);
            default:    reg_model = '0; // Clear bit and unmapped space
        endcase
    endfunction

    task automatic report_mismatch(input string what, input longint exp, input longint act);
        errors++;
        $display("** Error %0s %0s: expected %0d, actual %0d", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error in %0s: %0s", test_name, msg);
    endtask

    // ------------------------------------------------------------------
    // Port checks first, model updates after, all on pre-edge values
    // ------------------------------------------------------------------
    always @(posedge axi_clk) begin
        longint unsigned sum;
        if (!axi_reset_n) begin
            start_m    = 1'b0;
            clear_pend = 1'b0;
            width_m    = '0;
            height_m   = '0;
            bvalid_m   = 1'b0;
            rvalid_m   = 1'b0;
            col        = 0;
            row        = 0;
            beats      = 0;
            beat_due   = 1'b0;
            held       = 1'b0;
            exp_q.delete();
            last_q.delete();
        end else begin
            if (!start_m && s_axis_ready)
                report_failure("s_axis_ready is high while start is clear");
            if (beat_due && !m_axis_valid)
                report_failure("no output beat one cycle after its window was accepted");
            if (held && (!m_axis_valid || m_axis_data != held_data || m_axis_last != held_last))
                report_failure("output beat changed while m_axis_ready was low");
            if (s_axi_bvalid != bvalid_m)
                report_mismatch("bvalid", bvalid_m, s_axi_bvalid);
            if (s_axi_rvalid != rvalid_m)
                report_mismatch("rvalid", rvalid_m, s_axi_rvalid);
            if (s_axi_rvalid && s_axi_rready && s_axi_rdata != reg_model(raddr_m))
                report_mismatch("register read", reg_model(raddr_m), s_axi_rdata);

            if (m_axis_valid && m_axis_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output beat with no window pending");
                end else begin
                    beats++;
                    if (m_axis_data != exp_q[0])
                        report_mismatch("average", exp_q[0], m_axis_data);
                    if (m_axis_last != last_q[0])
                        report_mismatch("last flag", last_q[0], m_axis_last);
                    if (m_axis_last) begin
                        if (beats != (int'(width_m) - 2) * (int'(height_m) - 2))
                            report_mismatch("beat count",
                                (int'(width_m) - 2) * (int'(height_m) - 2), beats);
                        beats = 0;
                    end
                    void'(exp_q.pop_front());
                    void'(last_q.pop_front());
                end
            end
            held      = m_axis_valid && !m_axis_ready;
            held_data = m_axis_data;
            held_last = m_axis_last;
            beat_due  = 1'b0;

            // Pixel mirror and floor of the window sum over nine
            if (s_axis_valid && s_axis_ready) begin
                img[row][col] = s_axis_data;
                if (row >= 2 && col >= 2) begin
                    sum = 0;
                    for (int r = row - 2; r <= row; r++)
                        for (int c = col - 2; c <= col; c++)
                            sum = sum + img[r][c];
                    exp_q.push_back(pixel_t'(sum / 9));
                    last_q.push_back(row == height_m - 1 && col == width_m - 1);
                    beat_due = 1'b1;
                end
                if (col == width_m - 1) begin
                    col = 0;
                    row = (row == height_m - 1) ? 0 : row + 1; // Frame wrap
                end else begin
                    col++;
                end
            end

            if (clear_pend) begin
                start_m    = 1'b0;
                width_m    = '0;
                height_m   = '0;
                clear_pend = 1'b0;
            end
            if (s_axi_bvalid && s_axi_bready) bvalid_m = 1'b0;
            if (s_axi_rvalid && s_axi_rready) rvalid_m = 1'b0;
            if (s_axi_awvalid && s_axi_awready) waddr_m = s_axi_awaddr;
            if (s_axi_arvalid && s_axi_arready) begin
                raddr_m  = s_axi_araddr;
                rvalid_m = 1'b1;         // Data shows up at the same edge
            end
            if (s_axi_wvalid && s_axi_wready) begin
                bvalid_m = 1'b1;         // Response rises with the register update
                case (waddr_m)
                    REG_CTRL:   start_m    = s_axi_wdata[0];
                    REG_CLEAR:  clear_pend = s_axi_wdata[0];
                    REG_WIDTH:  width_m    = s_axi_wdata[10:0];
                    REG_HEIGHT: height_m   = s_axi_wdata[10:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_pool_top.sv */
/* Testbench for the pooling engine, frames from a table applied in a loop
   Stall masks repeat every 32 cycles; all comparing happens in pool_checker */

`timescale 1ns/10ps
`default_nettype none

module tb_pool_top;
    import pool_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_FRAMES     = 6;

    typedef enum int {F_AWREADY, F_WREADY, F_BVALID, F_ARREADY, F_RVALID} flag_t;

    typedef struct packed {
        logic [95:0] name;   // Test name as a string
        logic [15:0] width;
        logic [15:0] height;
        logic [31:0] seed;   // Added to the base seed
        logic [31:0] stall;  // Bit n drops m_axis_ready in cycle n mod 32
    } frame_t;

    frame_t frames [NUM_FRAMES] = '{
        '{"min_3x3",    16'd3,  16'd3, 32'd1, 32'h0000_0000},
        '{"rect_7x5",   16'd7,  16'd5, 32'd2, 32'h0000_0000},
        '{"same_7x5",   16'd7,  16'd5, 32'd3, 32'h0000_0000}, // Runs without a rewrite
        '{"wide_40x4",  16'd40, 16'd4, 32'd4, 32'h0000_0000},
        '{"stall_9x6",  16'd9,  16'd6, 32'd5, 32'hF0F0_3C0E},
        '{"stall_40x3", 16'd40, 16'd3, 32'd6, 32'h7F00_FF0F}
    };

    logic        axi_clk = 1'b0;
    logic        axi_reset_n;
    axil_addr_t  s_axi_awaddr;
    axil_addr_t  s_axi_araddr;
    pixel_t      s_axi_wdata;
    pixel_t      s_axi_rdata;
    pixel_t      s_axis_data;
    pixel_t      m_axis_data;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        s_axis_valid;
    logic        s_axis_ready;
    logic        m_axis_valid;
    logic        m_axis_last;
    logic        m_axis_ready;
    logic [95:0] test_name;
    int          errors;       // Driven by the checker
    int          timeouts = 0;
    logic        aborted = 1'b0; // Set by a timeout, later steps are skipped
    int          prog_w = 0;   // Last programmed frame size
    int          prog_h = 0;
    logic [31:0] rng;

    always #4 axi_clk = ~axi_clk;

    pool_top     u_dut (.*);
    pool_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        xorshift = y ^ (y << 5);
    endfunction

    function automatic logic flag_high(input flag_t sel);
        case (sel)
            F_AWREADY: flag_high = s_axi_awready;
            F_WREADY:  flag_high = s_axi_wready;
            F_BVALID:  flag_high = s_axi_bvalid;
            F_ARREADY: flag_high = s_axi_arready;
            default:   flag_high = s_axi_rvalid;
        endcase
    endfunction

    task automatic timed_out(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("Timeout in %0s while waiting for %0s", test_name, what);
    endtask

    // Polls at falling edges, where the flags are settled
    task automatic wait_flag(input flag_t sel, input string what);
        int n;
        n = 0;
        while (!aborted && !flag_high(sel)) begin
            if (n == TIMEOUT_CYCLES) begin
                timed_out(what);
            end else begin
                @(negedge axi_clk);
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite transactions, bready and rready stay high
    // ------------------------------------------------------------------
    task automatic reg_write(input axil_addr_t addr, input pixel_t data);
        if (aborted) return;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        wait_flag(F_AWREADY, "awready");
        @(negedge axi_clk);             // Address taken at the edge in between
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        wait_flag(F_WREADY, "wready");
        @(negedge axi_clk);
        s_axi_wvalid  = 1'b0;
        wait_flag(F_BVALID, "bvalid");
        @(negedge axi_clk);
    endtask

    task automatic reg_read(input axil_addr_t addr);
        if (aborted) return;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        wait_flag(F_ARREADY, "arready");
        @(negedge axi_clk);
        s_axi_arvalid = 1'b0;
        wait_flag(F_RVALID, "rvalid");
        @(negedge axi_clk);             // Read data checked at the edge in between
    endtask

    // Streams one frame and runs until its last beat leaves
    task automatic run_frame(input frame_t fr);
        int   taken;
        int   cyc;
        int   npix;
        logic done;
        taken = 0;
        cyc   = 0;
        npix  = int'(fr.width) * int'(fr.height);
        done  = 1'b0;
        rng   = xorshift(32'ha25f_2c43 + fr.seed);
        while (!done && !aborted) begin
            if (cyc == 4 * npix + TIMEOUT_CYCLES) begin
                timed_out("the last output beat of the frame");
            end else begin
                @(negedge axi_clk);
                m_axis_ready = !fr.stall[cyc % 32];
                s_axis_valid = (taken < npix);
                s_axis_data  = rng & 32'h0FFF_FFFF; // Below 2^28
                @(posedge axi_clk);
                if (s_axis_valid && s_axis_ready) begin
                    taken++;
                    rng = xorshift(rng);
                end
                done = m_axis_valid && m_axis_ready && m_axis_last;
                cyc++;
            end
        end
        @(negedge axi_clk);             // Next driver starts on a falling edge
    endtask

    initial begin
        axi_reset_n   = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        s_axis_valid  = 1'b0;
        s_axis_data   = '0;
        m_axis_ready  = 1'b1;
        test_name     = "reset";
        repeat (4) @(negedge axi_clk);
        axi_reset_n = 1'b1;

        test_name = "reg_readback";
        reg_write(REG_WIDTH, 32'd7);
        reg_write(REG_HEIGHT, 32'd5);
        reg_write(10'd12, 32'hFFFF_FFFF); // Unmapped, must not land anywhere
        reg_read(REG_WIDTH);
        reg_read(REG_HEIGHT);
        reg_read(10'd12);               // Unmapped

        test_name = "reg_clear";
        reg_write(REG_CTRL, 32'd1);
        reg_write(REG_CLEAR, 32'd1);
        reg_read(REG_CTRL);
        reg_read(REG_WIDTH);
        reg_read(REG_HEIGHT);
        reg_read(REG_CLEAR);
        s_axis_valid = 1'b1;            // Offered while start is 0
        repeat (6) @(negedge axi_clk);
        s_axis_valid = 1'b0;

        // --------------------------------------------------------------
        // Frame table, registers rewritten only when the size changes
        // --------------------------------------------------------------
        for (int f = 0; f < NUM_FRAMES && !aborted; f++) begin
            test_name = frames[f].name;
            if (int'(frames[f].width) != prog_w || int'(frames[f].height) != prog_h) begin
                reg_write(REG_WIDTH, pixel_t'(frames[f].width));
                reg_write(REG_HEIGHT, pixel_t'(frames[f].height));
                reg_write(REG_CTRL, 32'd1);
                prog_w = frames[f].width;
                prog_h = frames[f].height;
            end
            run_frame(frames[f]);
        end

        repeat (4) @(negedge axi_clk);
        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
